/* files.f */
+incdir+include
rtl/esfaPkg.sv
rtl/instrFetch.sv
rtl/tagStore.sv
rtl/progChecker.sv
rtl/esfaTop.sv
sim/esfaTb.sv

/* sim/esfaTb.sv */
`timescale 1ns/1ps

`include "esfa_settings.svh"

module esfaTb import esfaPkg::*;;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // Program words summed over all runs, and the number of runs
    localparam int TOTAL_LEN    = 210;
    localparam int NUM_RUNS     = 13;
    // Start, pipeline drain and idle gap of one run
    localparam int RUN_OVERHEAD = 16;
    localparam int LIMIT_CYCLES = RESET_CYCLES + 2 * TOTAL_LEN + NUM_RUNS * RUN_OVERHEAD;

    logic                  clk;
    logic                  rstN;
    logic                  progWrEn;
    logic [`ESFA_PC_W-1:0] progWrAddr;
    instrT                 progWrData;
    logic                  start;
    logic [`ESFA_PC_W:0]   progLength;
    logic                  running;
    logic                  done;
    logic                  passed;
    logic [7:0]            returnValue;

    // Program image that the next run loads
    instrT  prog [`ESFA_PROG_DEPTH];
    int     errorCount;
    int     checkCount;
    integer seed;

    esfaTop DUT (
        .clk         (clk),
        .rstN        (rstN),
        .progWrEn    (progWrEn),
        .progWrAddr  (progWrAddr),
        .progWrData  (progWrData),
        .start       (start),
        .progLength  (progLength),
        .running     (running),
        .done        (done),
        .passed      (passed),
        .returnValue (returnValue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Twice the expected run time
    initial begin
        #(2 * LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish in time, done never came");
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic checkReturn(input string name, input logic [7:0] expVal,
                               input logic [7:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERR t=%0t %s expected 0x%02h actual 0x%02h", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errorCount++;
            $display("ERR t=%0t %s expected %b actual %b", $time, name, expVal, actVal);
        end
    endtask

    ////////////////////
    // Program helpers
    ////////////////////

    function automatic instrT makeInstr(input logic w, input logic [7:0] idx,
                                        input logic [7:0] val, input logic expB,
                                        input logic [7:0] expV, input logic [7:0] sel,
                                        input logic chk);
        instrT ins;
        ins.willWrite   = w;
        ins.newIndex    = idx;
        ins.newValue    = val;
        ins.expValue    = expV;
        ins.expBool     = expB;
        ins.selector    = sel;
        ins.assertCheck = chk;
        return ins;
    endfunction

    // Software store that replays the program and stops at the first mismatch
    task automatic predictResult(input int len, output logic expPass, output logic [7:0] expRet);
        logic [7:0] vals [`ESFA_STORE_SIZE];
        logic       flags [`ESFA_STORE_SIZE];
        logic       rdFlag;
        logic [7:0] rdVal;
        instrT      ins;
        logic       failed;
        for (int i = 0; i < `ESFA_STORE_SIZE; i++) begin
            vals[i]  = 8'h00;
            flags[i] = 1'b0;
        end
        expPass = 1'b1;
        expRet  = `ESFA_PASS_CODE;
        failed  = 1'b0;
        for (int pc = 0; pc < len && !failed; pc++) begin
            ins = prog[pc];
            if (ins.willWrite) begin
                vals[ins.newIndex]  = ins.newValue;
                flags[ins.newIndex] = 1'b1;
            end
            rdFlag = flags[ins.selector];
            rdVal  = rdFlag ? vals[ins.selector] : 8'h00;
            if (ins.assertCheck && (rdFlag != ins.expBool || rdVal != ins.expValue)) begin
                failed  = 1'b1;
                expPass = 1'b0;
                expRet  = 8'(pc);
            end
        end
    endtask

    // Give every checked instruction its correct expectation
    task automatic fillExpectations(input int len);
        logic [7:0] vals [`ESFA_STORE_SIZE];
        logic       flags [`ESFA_STORE_SIZE];
        for (int i = 0; i < `ESFA_STORE_SIZE; i++) begin
            vals[i]  = 8'h00;
            flags[i] = 1'b0;
        end
        for (int pc = 0; pc < len; pc++) begin
            if (prog[pc].willWrite) begin
                vals[prog[pc].newIndex]  = prog[pc].newValue;
                flags[prog[pc].newIndex] = 1'b1;
            end
            if (prog[pc].assertCheck) begin
                prog[pc].expBool  = flags[prog[pc].selector];
                prog[pc].expValue = flags[prog[pc].selector] ? vals[prog[pc].selector] : 8'h00;
            end
        end
    endtask

    task automatic loadProgram(input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            progWrEn   <= 1'b1;
            progWrAddr <= i[`ESFA_PC_W-1:0];
            progWrData <= prog[i];
        end
        @(posedge clk);
        progWrEn <= 1'b0;
    endtask

    // Load, start, wait for done and compare with the model
    task automatic runAndCheck(input string testName, input int len,
                               input logic wantPass, input logic [7:0] wantRet);
        logic       modelPass;
        logic [7:0] modelRet;
        predictResult(len, modelPass, modelRet);
        if (modelPass !== wantPass || modelRet !== wantRet) begin
            errorCount++;
            $display("%s: the model result differs from the result the test was built for",
                     testName);
        end
        loadProgram(len);
        @(posedge clk);
        start      <= 1'b1;
        progLength <= len[`ESFA_PC_W:0];
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkFlag("running", 1'b1, running);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        checkFlag("passed", modelPass, passed);
        checkReturn("returnValue", modelRet, returnValue);
        checkFlag("running", 1'b0, running);
        @(negedge clk);
        checkFlag("done", 1'b0, done);
        checkReturn("returnValue", modelRet, returnValue);
        // Let a halted fetch settle before the next load
        repeat (3) @(posedge clk);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic testWriteRead();
        prog[0] = makeInstr(1'b1, 8'h05, 8'h5A, 1'b1, 8'h5A, 8'h05, 1'b1);
        prog[1] = makeInstr(1'b1, 8'h22, 8'hC3, 1'b1, 8'hC3, 8'h22, 1'b1);
        prog[2] = makeInstr(1'b1, 8'hFF, 8'h01, 1'b1, 8'h5A, 8'h05, 1'b1);
        prog[3] = makeInstr(1'b1, 8'h00, 8'h80, 1'b1, 8'h01, 8'hFF, 1'b1);
        prog[4] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'hC3, 8'h22, 1'b1);
        prog[5] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'h80, 8'h00, 1'b1);
        // Written zero still reads with the flag set
        prog[6] = makeInstr(1'b1, 8'h7E, 8'h00, 1'b1, 8'h00, 8'h7E, 1'b1);
        prog[7] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'h5A, 8'h05, 1'b1);
        runAndCheck("testWriteRead", 8, 1'b1, `ESFA_PASS_CODE);
    endtask

    task automatic testUnwritten();
        prog[0] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h33, 1'b1);
        prog[1] = makeInstr(1'b1, 8'h34, 8'h12, 1'b1, 8'h12, 8'h34, 1'b1);
        prog[2] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h35, 1'b1);
        prog[3] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h33, 1'b1);
        runAndCheck("testUnwritten", 4, 1'b1, `ESFA_PASS_CODE);
        prog[2].expBool = 1'b1;
        runAndCheck("testUnwritten", 4, 1'b0, 8'd2);
        prog[2].expBool  = 1'b0;
        prog[0].expValue = 8'h01;
        runAndCheck("testUnwritten", 4, 1'b0, 8'd0);
    endtask

    task automatic testWrongExpect();
        int failAt [3];
        failAt = '{0, 5, 11};
        foreach (failAt[n]) begin
            for (int i = 0; i < 16; i++) begin
                prog[i] = makeInstr((i % 3) != 2, 8'h10 + 8'(i % 5), 8'hA0 + 8'(i),
                                    1'b0, 8'h00, 8'h10 + 8'((i + 2) % 5), 1'b1);
            end
            fillExpectations(16);
            prog[failAt[n]].expValue ^= 8'h01;
            // Later mistakes must not change the reported address
            prog[failAt[n] + 2].expBool ^= 1'b1;
            runAndCheck("testWrongExpect", 16, 1'b0, 8'(failAt[n]));
        end
    endtask

    task automatic testOverwrite();
        prog[0] = makeInstr(1'b1, 8'h40, 8'h11, 1'b1, 8'h11, 8'h40, 1'b1);
        prog[1] = makeInstr(1'b1, 8'h40, 8'h22, 1'b0, 8'h00, 8'h41, 1'b1);
        prog[2] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'h22, 8'h40, 1'b1);
        prog[3] = makeInstr(1'b1, 8'h41, 8'h33, 1'b1, 8'h33, 8'h41, 1'b1);
        // Wrong expectation that is never checked
        prog[4] = makeInstr(1'b1, 8'h40, 8'h44, 1'b0, 8'h99, 8'h40, 1'b0);
        prog[5] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'h44, 8'h40, 1'b1);
        runAndCheck("testOverwrite", 6, 1'b1, `ESFA_PASS_CODE);
    endtask

    task automatic testRestartClears();
        prog[0] = makeInstr(1'b1, 8'h80, 8'hAA, 1'b1, 8'hAA, 8'h80, 1'b1);
        prog[1] = makeInstr(1'b1, 8'h81, 8'hBB, 1'b1, 8'hBB, 8'h81, 1'b1);
        prog[2] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'hAA, 8'h80, 1'b1);
        runAndCheck("testRestartClears", 3, 1'b1, `ESFA_PASS_CODE);
        prog[0] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h80, 1'b1);
        prog[1] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h81, 1'b1);
        prog[2] = makeInstr(1'b1, 8'h82, 8'hCC, 1'b0, 8'h00, 8'h80, 1'b1);
        runAndCheck("testRestartClears", 3, 1'b1, `ESFA_PASS_CODE);
        prog[0] = makeInstr(1'b0, 8'h00, 8'h00, 1'b1, 8'hAA, 8'h80, 1'b1);
        prog[1] = makeInstr(1'b0, 8'h00, 8'h00, 1'b0, 8'h00, 8'h82, 1'b1);
        runAndCheck("testRestartClears", 2, 1'b0, 8'd0);
    endtask

    task automatic testRandom(input logic corrupt);
        logic       wantPass;
        logic [7:0] wantRet;
        for (int i = 0; i < `ESFA_PROG_DEPTH; i++) begin
            // Mostly a narrow index range so reads hit earlier writes
            prog[i] = makeInstr(1'($random(seed)), 8'($random(seed) & 32'h0F), 8'($random(seed)),
                                1'($random(seed)), 8'($random(seed)),
                                8'($random(seed) & 32'h0F), (($random(seed) & 32'h3) != 0));
            if (($random(seed) & 32'h7) == 0) begin
                prog[i].selector = 8'($random(seed));
            end
        end
        fillExpectations(`ESFA_PROG_DEPTH);
        // Correct expectations pass unless a check is corrupted below
        wantPass = 1'b1;
        wantRet  = `ESFA_PASS_CODE;
        if (corrupt) begin
            for (int i = 0; i < `ESFA_PROG_DEPTH; i++) begin
                if (prog[i].assertCheck && (($random(seed) & 32'h1F) == 0)) begin
                    prog[i].expValue ^= 8'h10;
                    // The first corrupted check is where the run stops
                    if (wantPass) begin
                        wantPass = 1'b0;
                        wantRet  = 8'(i);
                    end
                end
            end
        end
        runAndCheck("testRandom", `ESFA_PROG_DEPTH, wantPass, wantRet);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        seed       = 50;
        errorCount = 0;
        checkCount = 0;
        rstN       = 1'b0;
        progWrEn   = 1'b0;
        progWrAddr = '0;
        progWrData = '0;
        start      = 1'b0;
        progLength = 7'd1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);

        testWriteRead();
        testUnwritten();
        testWrongExpect();
        testOverwrite();
        testRestartClears();
        testRandom(1'b0);
        testRandom(1'b1);

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* rtl/esfaTop.sv */
`timescale 1ns/1ps

`include "esfa_settings.svh"

module esfaTop import esfaPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  progWrEn,
    input  logic [`ESFA_PC_W-1:0] progWrAddr,
    input  instrT                 progWrData,
    input  logic                  start,
    input  logic [`ESFA_PC_W:0]   progLength,
    output logic                  running,
    output logic                  done,
    output logic                  passed,
    output logic [7:0]            returnValue
);

    ////////////////////
    // Stage links
    ////////////////////

    fetchT fetch;
    checkT check;
    // Stops issue after a failed check
    logic  halt;

    ////////////////////
    // Stages
    ////////////////////

    // Program memory and issue
    instrFetch uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .progWrEn   (progWrEn),
        .progWrAddr (progWrAddr),
        .progWrData (progWrData),
        .start      (start),
        .progLength (progLength),
        .halt       (halt),
        .fetch      (fetch)
    );

    // Tagged store
    tagStore uStore (
        .clk   (clk),
        .rstN  (rstN),
        .start (start),
        .fetch (fetch),
        .check (check)
    );

    // Verdict and return value
    progChecker uChecker (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .check       (check),
        .halt        (halt),
        .running     (running),
        .done        (done),
        .passed      (passed),
        .returnValue (returnValue)
    );

endmodule

/* rtl/progChecker.sv */
`timescale 1ns/1ps

`include "esfa_settings.svh"

module progChecker import esfaPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  checkT      check,
    output logic       halt,
    output logic       running,
    output logic       done,
    output logic       passed,
    output logic [7:0] returnValue
);

    logic mismatch;
    logic failNow;
    logic passNow;

    // Readback differs from the expectation on a checked instruction
    assign mismatch = check.valid && check.assertCheck &&
                      ((check.resultBool != check.expBool) ||
                       (check.resultValue != check.expValue));

    // Results arriving after the run has ended are dropped
    assign failNow = running && mismatch;
    assign passNow = running && check.valid && check.last && !mismatch;

    ////////////////////
    // Run state
    ////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running     <= 1'b0;
            halt        <= 1'b0;
            done        <= 1'b0;
            passed      <= 1'b0;
            returnValue <= '0;
        end else begin
            done <= 1'b0;
            if (start && !running) begin
                running     <= 1'b1;
                halt        <= 1'b0;
                passed      <= 1'b0;
                returnValue <= '0;
            end else if (failNow) begin
                // Report the failing address
                running     <= 1'b0;
                halt        <= 1'b1;
                done        <= 1'b1;
                returnValue <= 8'(check.pc);
            end else if (passNow) begin
                running     <= 1'b0;
                done        <= 1'b1;
                passed      <= 1'b1;
                returnValue <= `ESFA_PASS_CODE;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // End of run is a single pulse
    doneIsPulse: assert property (
        @(posedge clk) disable iff (!rstN) done |=> !done
    );

    // A run ends either passed or halted on a failure
    passXorFail: assert property (
        @(posedge clk) disable iff (!rstN) !(passed && halt)
    );

    // Result holds from done until the next start
    resultStable: assert property (
        @(posedge clk) disable iff (!rstN)
        (done ##1 !start) |-> ($stable(returnValue) && $stable(passed))
    );

endmodule

/* rtl/tagStore.sv */
`timescale 1ns/1ps

`include "esfa_settings.svh"

module tagStore import esfaPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    input  logic  start,
    input  fetchT fetch,
    output checkT check
);

    // Entry values and their written flags
    logic [7:0]                  valueMem [`ESFA_STORE_SIZE];
    logic [`ESFA_STORE_SIZE-1:0] written;

    logic  doWrite;
    logic  hitNew;
    checkT nextCheck;

    assign doWrite = fetch.valid && fetch.instr.willWrite;
    // Read of the index written by the same instruction
    assign hitNew  = doWrite && (fetch.instr.newIndex == fetch.instr.selector);

    ////////////////////
    // Store update
    ////////////////////

    always_ff @(posedge clk) begin
        if (doWrite) begin
            valueMem[fetch.instr.newIndex] <= fetch.instr.newValue;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            written <= '0;
        end else begin
            if (start) begin
                written <= '0;
            end
            if (doWrite) begin
                written[fetch.instr.newIndex] <= 1'b1;
            end
        end
    end

    ////////////////////
    // Readback
    ////////////////////

    always_comb begin
        nextCheck             = '0;
        nextCheck.valid       = fetch.valid;
        nextCheck.pc          = fetch.pc;
        nextCheck.last        = fetch.last;
        nextCheck.assertCheck = fetch.instr.assertCheck;
        nextCheck.expBool     = fetch.instr.expBool;
        nextCheck.expValue    = fetch.instr.expValue;
        if (hitNew) begin
            // Write goes first, so forward the new value
            nextCheck.resultBool  = 1'b1;
            nextCheck.resultValue = fetch.instr.newValue;
        end else if (written[fetch.instr.selector]) begin
            nextCheck.resultBool  = 1'b1;
            nextCheck.resultValue = valueMem[fetch.instr.selector];
        end
        // Unwritten entries read as flag 0, value 0
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            check <= '0;
        end else begin
            check <= nextCheck;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // One result for every issued instruction, one cycle later
    checkFollowsFetch: assert property (
        @(posedge clk) disable iff (!rstN) fetch.valid |=> check.valid
    );

    noStrayCheck: assert property (
        @(posedge clk) disable iff (!rstN) !fetch.valid |=> !check.valid
    );

endmodule

/* rtl/instrFetch.sv */
`timescale 1ns/1ps

`include "esfa_settings.svh"

module instrFetch import esfaPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  progWrEn,
    input  logic [`ESFA_PC_W-1:0] progWrAddr,
    input  instrT                 progWrData,
    input  logic                  start,
    input  logic [`ESFA_PC_W:0]   progLength,
    input  logic                  halt,
    output fetchT                 fetch
);

    // Program storage
    instrT progMem [`ESFA_PROG_DEPTH];

    logic                  issuing;
    logic [`ESFA_PC_W-1:0] pc;
    logic [`ESFA_PC_W-1:0] lastPc;
    logic                  atLast;

    // Issued word from a registered read of the program memory
    instrT                 readWord;
    logic                  fetchValid;
    logic [`ESFA_PC_W-1:0] fetchPc;
    logic                  fetchLast;

    assign atLast = (pc == lastPc);

    ////////////////////
    // Load port and read
    ////////////////////

    always_ff @(posedge clk) begin
        if (progWrEn) begin
            progMem[progWrAddr] <= progWrData;
        end
        readWord <= progMem[pc];
    end

    ////////////////////
    // Program counter
    ////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issuing <= 1'b0;
            pc      <= '0;
            lastPc  <= '0;
        end else if (start && !issuing) begin
            // Length is 1 to 64, so the last address fits in the pc width
            issuing <= 1'b1;
            pc      <= '0;
            lastPc  <= `ESFA_PC_W'(progLength - 1'b1);
        end else if (issuing) begin
            if (halt || atLast) begin
                issuing <= 1'b0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Tag travels with the word read in the same cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
            fetchPc    <= '0;
            fetchLast  <= 1'b0;
        end else begin
            fetchValid <= issuing && !halt;
            fetchPc    <= pc;
            fetchLast  <= atLast;
        end
    end

    assign fetch = '{valid: fetchValid, pc: fetchPc, last: fetchLast, instr: readWord};

    ////////////////////
    // Checks
    ////////////////////

    // Program must not change under a running fetch
    noLoadWhileIssuing: assert property (
        @(posedge clk) disable iff (!rstN) issuing |-> !progWrEn
    );

    // Checker halt has to stop issue by the next edge
    noFetchAfterHalt: assert property (
        @(posedge clk) disable iff (!rstN) halt |=> !fetch.valid
    );

endmodule

/* rtl/esfaPkg.sv */
`include "esfa_settings.svh"

package esfaPkg;

    ////////////////////
    // Program word
    ////////////////////

    // One 35-bit instruction with the first field at the MSB
    typedef struct packed {
        logic       willWrite;
        logic [7:0] newIndex;
        logic [7:0] newValue;
        // Expected value of the selected entry
        logic [7:0] expValue;
        // Expected written flag of the selected entry
        logic       expBool;
        logic [7:0] selector;
        // Compare the readback against the expectation
        logic       assertCheck;
    } instrT;

    ////////////////////
    // Pipeline stages
    ////////////////////

    // Instruction issued by the fetch stage
    typedef struct packed {
        logic                  valid;
        logic [`ESFA_PC_W-1:0] pc;
        // Final word of the program
        logic                  last;
        instrT                 instr;
    } fetchT;

    // Store readback paired with what the program expects
    typedef struct packed {
        logic                  valid;
        logic [`ESFA_PC_W-1:0] pc;
        logic                  last;
        logic                  assertCheck;
        logic                  expBool;
        logic [7:0]            expValue;
        // Written flag of the selected entry
        logic                  resultBool;
        // Entry value, zero while unwritten
        logic [7:0]            resultValue;
    } checkT;

endpackage

/* include/esfa_settings.svh */
`ifndef ESFA_SETTINGS_SVH
`define ESFA_SETTINGS_SVH

////////////////////
// Program memory
////////////////////

// Number of program words
`define ESFA_PROG_DEPTH 64
// Program address width as log2 of the depth
`define ESFA_PC_W 6

////////////////////
// Store and result
////////////////////

// Tagged store entries behind an 8-bit index
`define ESFA_STORE_SIZE 256
// Return value when every checked instruction matches
`define ESFA_PASS_CODE 8'h1E

`endif
